//--- quote_order_gen.f
+incdir+verification
verilog/order_entry_pkg.sv
verilog/quote_stager.sv
verilog/add_order_builder.sv
verilog/message_merger.sv
verilog/quote_order_gen.sv
verification/quote_order_gen_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the quote_order_gen testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module quote_order_gen_tb -f quote_order_gen.f \
    -o sim_quote_order_gen

# keep the log even when the simulation exits with an error
status=0
./obj_dir/sim_quote_order_gen > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit "$status"
fi

if grep -qx '>>> PASS' sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1

//--- verification/quote_order_gen_tests.svh
// nothing may leave after reset while no quote was sent
task automatic test_idle_after_reset();
    begin
        // credits on offer so a stray queue entry would show up as beats
        credit_mode = CREDIT_AMPLE;
        repeat (20) begin
            @(posedge i_clk);
            #1;
        end
        if (beats_total != 0 || credit_returns != 0) begin
            check_errors++;
            $display("activity after reset with no quote sent, %0d beats and %0d credits",
                     beats_total, credit_returns);
        end
    end
endtask

// one quote with references 0 and 1
task automatic test_single_quote();
    order_entry_pkg::quote_t q;
    int returns_before;
    begin
        returns_before = credit_returns;
        credit_mode    = CREDIT_AMPLE;
        q.symbol       = order_entry_pkg::AAPL;
        q.buy_price    = 32'd1502500;
        q.sell_price   = 32'd1502600;
        q.quantity     = 32'd100;
        q.locate       = 16'h0012;
        q.tracking     = 16'hbeef;
        q.timestamp    = 48'h0123456789ab;
        send_quote(q);
        wait_drained(200);
        if (credit_returns - returns_before != 1) begin
            check_errors++;
            $display("single quote returned %0d quote credits instead of one",
                     credit_returns - returns_before);
        end
    end
endtask

// symbol name lands in w6 and w7
task automatic test_all_symbols();
    order_entry_pkg::quote_t q;
    begin
        credit_mode = CREDIT_AMPLE;
        for (int s = 0; s < 4; s++) begin
            q        = random_quote();
            q.symbol = order_entry_pkg::symbol_e'(s[1:0]);
            send_quote(q);
        end
        wait_drained(4 * 80 + 100);
    end
endtask

// fill every queue slot without gaps
task automatic test_back_to_back();
    int returns_before;
    begin
        returns_before = credit_returns;
        credit_mode    = CREDIT_AMPLE;
        repeat (QUOTE_DEPTH) begin
            send_quote(random_quote());
        end
        wait_drained(QUOTE_DEPTH * 80 + 100);
        if (credit_returns - returns_before != QUOTE_DEPTH) begin
            check_errors++;
            $display("%0d back-to-back quotes returned %0d quote credits",
                     QUOTE_DEPTH, credit_returns - returns_before);
        end
    end
endtask

// sink grants in short bursts
task automatic test_backpressure();
    begin
        credit_mode = CREDIT_BURST;
        repeat (BURST_QUOTES) begin
            send_quote(random_quote());
        end
        wait_drained(BURST_QUOTES * 80 + 100);
    end
endtask

// random quotes with random gaps and random grants
task automatic test_random_stream();
    logic [31:0] gap;
    begin
        credit_mode = CREDIT_RANDOM;
        repeat (RANDOM_QUOTES) begin
            send_quote(random_quote());
            gap = $random(seed);
            repeat (gap[1:0]) begin
                @(posedge i_clk);
                #1;
            end
        end
        wait_drained(RANDOM_QUOTES * 80 + 100);
        credit_mode = CREDIT_NONE;
    end
endtask

//--- verification/quote_order_gen_tb.sv
`timescale 1ns/100ps

module quote_order_gen_tb;

    localparam int QUOTE_DEPTH    = 4;
    localparam int OUT_CREDIT_MAX = 16;
    localparam int CLK_PERIOD     = 10;
    localparam int BURST_QUOTES   = 6;
    localparam int RANDOM_QUOTES  = 40;
    // every quote of every test, two nine-word messages each
    localparam int TOTAL_BEATS = (5 + QUOTE_DEPTH + BURST_QUOTES + RANDOM_QUOTES) * 18;
    localparam int WATCHDOG_NS = TOTAL_BEATS * 40 * CLK_PERIOD + 2000;

    // sink credit patterns
    localparam int CREDIT_NONE   = 0;
    localparam int CREDIT_AMPLE  = 1;
    localparam int CREDIT_BURST  = 2;
    localparam int CREDIT_RANDOM = 3;

    logic                       i_clk;
    logic                       i_arst_n;
    logic                       i_quote_valid;
    order_entry_pkg::quote_t    i_quote;
    logic                       o_quote_credit;
    logic                       i_out_credit;
    logic                       o_out_valid;
    order_entry_pkg::out_beat_t o_out_beat;

    integer seed        = 32'hbeb6;
    integer credit_seed = 32'hbeb6;
    logic [31:0] credit_rnd;

    // expected beats, oldest first
    order_entry_pkg::out_beat_t exp_q[$];
    order_entry_pkg::out_beat_t exp_beat;
    // next buy reference of the model
    logic [61:0] model_ref = '0;

    int quotes_sent    = 0;
    int credit_returns = 0;
    int beats_total    = 0;
    int grants_total   = 0;
    int credit_mode    = CREDIT_NONE;
    int cycle_cnt      = 0;
    int value_errors   = 0;
    int stream_errors  = 0;
    int check_errors   = 0;
    int timeout_errors = 0;

    quote_order_gen #(
        .QUOTE_DEPTH    (QUOTE_DEPTH),
        .OUT_CREDIT_MAX (OUT_CREDIT_MAX)
    ) quote_order_gen_inst (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_quote_valid  (i_quote_valid),
        .i_quote        (i_quote),
        .o_quote_credit (o_quote_credit),
        .i_out_credit   (i_out_credit),
        .o_out_valid    (o_out_valid),
        .o_out_beat     (o_out_beat)
    );

    initial i_clk = 1'b0;
    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    // output monitor, compares against the model queue
    always @(posedge i_clk) begin
        if (i_arst_n && o_quote_credit) begin
            credit_returns++;
            if (credit_returns > quotes_sent) begin
                stream_errors++;
                $display("quote credit at %0t with no quote outstanding", $time);
            end
        end
        if (i_arst_n && o_out_valid) begin
            beats_total++;
            if (beats_total > grants_total) begin
                stream_errors++;
                $display("beat %0d at %0t sent beyond the %0d credits granted",
                         beats_total, $time, grants_total);
            end
            if (exp_q.size() == 0) begin
                stream_errors++;
                $display("output beat at %0t while no message was expected", $time);
            end else begin
                exp_beat = exp_q.pop_front();
                if (o_out_beat !== exp_beat) begin
                    value_errors++;
                    $display("[ERROR] %0t: beat %0d got %h f%b l%b, expected %h f%b l%b",
                             $time, beats_total, o_out_beat.data, o_out_beat.first,
                             o_out_beat.last, exp_beat.data, exp_beat.first, exp_beat.last);
                end
            end
        end
    end

    // downstream sink, never more credit out than OUT_CREDIT_MAX
    initial begin
        i_out_credit = 1'b0;
        forever begin
            @(posedge i_clk);
            #1;
            cycle_cnt++;
            credit_rnd   = $random(credit_seed);
            i_out_credit = 1'b0;
            if (i_arst_n && (grants_total - beats_total) < OUT_CREDIT_MAX) begin
                case (credit_mode)
                    CREDIT_AMPLE:  i_out_credit = 1'b1;
                    // three grants then five idle cycles
                    CREDIT_BURST:  i_out_credit = (cycle_cnt % 8) < 3;
                    CREDIT_RANDOM: i_out_credit = credit_rnd[0];
                    default:       i_out_credit = 1'b0;
                endcase
            end
            if (i_out_credit) begin
                grants_total++;
            end
        end
    end

    function automatic logic [63:0] symbol_ascii(input order_entry_pkg::symbol_e sym);
        case (sym)
            order_entry_pkg::AAPL:  return 64'h4141504c20202020;
            order_entry_pkg::AMZN:  return 64'h414d5a4e20202020;
            order_entry_pkg::GOOGL: return 64'h474f4f474c202020;
            default:                return 64'h4d53465420202020;
        endcase
    endfunction

    // nine expected words of one side
    task automatic push_message(input order_entry_pkg::quote_t q, input logic sell,
                                input logic [61:0] order_ref);
        logic [31:0] words [9];
        logic [63:0] ascii;
        order_entry_pkg::out_beat_t beat;
        begin
            ascii    = symbol_ascii(q.symbol);
            words[0] = {q.tracking[7:0], q.locate, 8'h41};
            words[1] = {q.timestamp[23:0], q.tracking[15:8]};
            words[2] = {order_ref[7:0], q.timestamp[47:24]};
            words[3] = order_ref[39:8];
            // side bit then side code 00 or 01
            words[4] = {7'b0, sell, 1'b0, sell, order_ref[61:40]};
            words[5] = q.quantity;
            words[6] = ascii[31:0];
            words[7] = ascii[63:32];
            words[8] = sell ? q.sell_price : q.buy_price;
            for (int i = 0; i < 9; i++) begin
                beat.data  = words[i];
                beat.first = (i == 0);
                beat.last  = (i == 8);
                exp_q.push_back(beat);
            end
        end
    endtask

    function automatic order_entry_pkg::quote_t random_quote();
        order_entry_pkg::quote_t q;
        logic [31:0] rnd;
        rnd                 = $random(seed);
        q.symbol            = order_entry_pkg::symbol_e'(rnd[1:0]);
        q.tracking          = rnd[31:16];
        rnd                 = $random(seed);
        q.locate            = rnd[15:0];
        q.timestamp[47:32]  = rnd[31:16];
        q.timestamp[31:0]   = $random(seed);
        q.buy_price         = $random(seed);
        q.sell_price        = $random(seed);
        q.quantity          = $random(seed);
        return q;
    endfunction

    // called and returns one ns after a rising edge
    task automatic send_quote(input order_entry_pkg::quote_t q);
        begin
            // sender side credit count
            while (quotes_sent - credit_returns >= QUOTE_DEPTH) begin
                @(posedge i_clk);
                #1;
            end
            i_quote_valid = 1'b1;
            i_quote       = q;
            quotes_sent++;
            push_message(q, 1'b0, model_ref);
            push_message(q, 1'b1, model_ref + 62'd1);
            model_ref += 62'd2;
            @(posedge i_clk);
            #1;
            i_quote_valid = 1'b0;
        end
    endtask

    // all beats seen and every quote credit back
    task automatic wait_drained(input int max_cycles);
        int cycles;
        begin
            cycles = 0;
            while ((exp_q.size() != 0 || credit_returns != quotes_sent)
                   && cycles < max_cycles) begin
                @(posedge i_clk);
                #1;
                cycles++;
            end
            if (exp_q.size() != 0 || credit_returns != quotes_sent) begin
                timeout_errors++;
                $display("stream did not drain within %0d cycles at %0t, %0d beats missing",
                         max_cycles, $time, exp_q.size());
            end
        end
    endtask

    `include "quote_order_gen_tests.svh"

    initial begin
        i_arst_n      = 1'b0;
        i_quote_valid = 1'b0;
        i_quote       = '0;
        repeat (8) @(posedge i_clk);
        #1;
        i_arst_n = 1'b1;

        test_idle_after_reset();
        test_single_quote();
        test_all_symbols();
        test_back_to_back();
        test_backpressure();
        test_random_stream();

        $display("errors: value %0d, stream %0d, check %0d, timeout %0d",
                 value_errors, stream_errors, check_errors, timeout_errors);
        if (value_errors + stream_errors + check_errors + timeout_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // hang guard
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run hung before the tests ended",
                 WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- verilog/quote_order_gen.sv
`timescale 1ns/100ps

module quote_order_gen #(
    parameter int QUOTE_DEPTH    = 4,
    parameter int OUT_CREDIT_MAX = 16
) (
    input  logic                       i_clk,
    input  logic                       i_arst_n,

    // quotes in, credits back
    input  logic                       i_quote_valid,
    input  order_entry_pkg::quote_t    i_quote,
    output logic                       o_quote_credit,

    // message stream out, credits in
    input  logic                       i_out_credit,
    output logic                       o_out_valid,
    output order_entry_pkg::out_beat_t o_out_beat
);

    // stager to builders
    logic                       order_valid;
    order_entry_pkg::order_t    buy_order;
    order_entry_pkg::order_t    sell_order;

    // builders to merger
    logic                       buy_valid;
    logic                       sell_valid;
    order_entry_pkg::out_beat_t buy_word;
    order_entry_pkg::out_beat_t sell_word;
    logic                       buy_pop;
    logic                       sell_pop;

    quote_stager quote_stager_inst (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_quote_valid (i_quote_valid),
        .i_quote       (i_quote),
        .o_order_valid (order_valid),
        .o_buy_order   (buy_order),
        .o_sell_order  (sell_order)
    );

    // buy side formatter
    add_order_builder #(
        .SIDE        (order_entry_pkg::BUY),
        .QUOTE_DEPTH (QUOTE_DEPTH)
    ) buy_builder_inst (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_order_valid (order_valid),
        .i_order       (buy_order),
        .i_word_pop    (buy_pop),
        .o_word_valid  (buy_valid),
        .o_word        (buy_word)
    );

    // sell side formatter
    add_order_builder #(
        .SIDE        (order_entry_pkg::SELL),
        .QUOTE_DEPTH (QUOTE_DEPTH)
    ) sell_builder_inst (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_order_valid (order_valid),
        .i_order       (sell_order),
        .i_word_pop    (sell_pop),
        .o_word_valid  (sell_valid),
        .o_word        (sell_word)
    );

    message_merger #(
        .OUT_CREDIT_MAX (OUT_CREDIT_MAX)
    ) message_merger_inst (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_buy_valid    (buy_valid),
        .i_buy_word     (buy_word),
        .o_buy_pop      (buy_pop),
        .i_sell_valid   (sell_valid),
        .i_sell_word    (sell_word),
        .o_sell_pop     (sell_pop),
        .i_out_credit   (i_out_credit),
        .o_out_valid    (o_out_valid),
        .o_out_beat     (o_out_beat),
        .o_quote_credit (o_quote_credit)
    );

endmodule

//--- verilog/message_merger.sv
`timescale 1ns/100ps

module message_merger #(
    parameter int OUT_CREDIT_MAX = 16
) (
    input  logic                       i_clk,
    input  logic                       i_arst_n,

    // buy builder head
    input  logic                       i_buy_valid,
    input  order_entry_pkg::out_beat_t i_buy_word,
    output logic                       o_buy_pop,

    // sell builder head
    input  logic                       i_sell_valid,
    input  order_entry_pkg::out_beat_t i_sell_word,
    output logic                       o_sell_pop,

    // downstream sink
    input  logic                       i_out_credit,
    output logic                       o_out_valid,
    output order_entry_pkg::out_beat_t o_out_beat,

    // back to the quote sender
    output logic                       o_quote_credit
);

    localparam int CNT_W = $clog2(OUT_CREDIT_MAX + 1);

    typedef enum logic [1:0] {
        IDLE,
        SEND_BUY,
        SEND_SELL
    } state_e;

    state_e           state;
    logic [CNT_W-1:0] credit_cnt;
    logic             has_credit;
    logic             send;
    // sell w8 went out this cycle
    logic             sell_done;

    assign has_credit = (credit_cnt != '0);

    // one word per cycle, buy message fully before sell message
    assign o_buy_pop  = (state == SEND_BUY) && i_buy_valid && has_credit;
    assign o_sell_pop = (state == SEND_SELL) && i_sell_valid && has_credit;
    assign send       = o_buy_pop || o_sell_pop;

    // sequencing
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                // both halves of the quote must be queued
                IDLE: begin
                    if (i_buy_valid && i_sell_valid) begin
                        state <= SEND_BUY;
                    end
                end
                SEND_BUY: begin
                    if (o_buy_pop && i_buy_word.last) begin
                        state <= SEND_SELL;
                    end
                end
                SEND_SELL: begin
                    if (o_sell_pop && i_sell_word.last) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // output credits, grant and spend may land together
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            credit_cnt <= '0;
        end else begin
            case ({i_out_credit, send})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // registered output valid and quote credit
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_out_valid    <= 1'b0;
            sell_done      <= 1'b0;
            o_quote_credit <= 1'b0;
        end else begin
            o_out_valid    <= send;
            sell_done      <= o_sell_pop && i_sell_word.last;
            // one cycle behind the last sell beat on the output
            o_quote_credit <= sell_done;
        end
    end

    // beat payload
    always_ff @(posedge i_clk) begin
        if (send) begin
            o_out_beat <= o_buy_pop ? i_buy_word : i_sell_word;
        end
    end

    // sink grants more than it has room for
    a_credit_bound : assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        credit_cnt <= CNT_W'(OUT_CREDIT_MAX)
    );

    // every beat on the output was paid for
    a_beat_paid : assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        o_out_valid |-> $past(has_credit)
    );

endmodule

//--- verilog/add_order_builder.sv
`timescale 1ns/100ps

module add_order_builder #(
    parameter order_entry_pkg::side_e SIDE        = order_entry_pkg::BUY,
    parameter int                     QUOTE_DEPTH = 4
) (
    input  logic                       i_clk,
    input  logic                       i_arst_n,

    // from the stager
    input  logic                       i_order_valid,
    input  order_entry_pkg::order_t    i_order,

    // word stream towards the merger
    input  logic                       i_word_pop,
    output logic                       o_word_valid,
    output order_entry_pkg::out_beat_t o_word
);

    localparam int PTR_W = (QUOTE_DEPTH > 1) ? $clog2(QUOTE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUOTE_DEPTH + 1);
    localparam logic [3:0] LAST_IDX = 4'(order_entry_pkg::MSG_WORDS - 1);
    // two-bit side code of word 4
    localparam logic [1:0] SIDE_CODE = {1'b0, SIDE};

    // queued orders
    order_entry_pkg::order_t queue_mem [QUOTE_DEPTH];
    order_entry_pkg::order_t head;

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    // word of the head message to show next
    logic [3:0]       word_idx;
    logic             msg_done;
    logic [31:0]      word_data;

    // wrap for depths that are not a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(QUOTE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // last word leaving, head entry is freed
    assign msg_done = i_word_pop && (word_idx == LAST_IDX);

    // queue storage
    always_ff @(posedge i_clk) begin
        if (i_order_valid) begin
            queue_mem[wr_ptr] <= i_order;
        end
    end

    // pointers, fill count and word index
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            word_idx <= '0;
        end else begin
            if (i_order_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (msg_done) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({i_order_valid, msg_done})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (i_word_pop) begin
                word_idx <= msg_done ? 4'd0 : word_idx + 4'd1;
            end
        end
    end

    // word select from the head order
    always_comb begin
        head = queue_mem[rd_ptr];
        case (word_idx)
            4'd0: word_data = {head.tracking[7:0], head.locate,
                               order_entry_pkg::ADD_ORDER_TYPE};
            4'd1: word_data = {head.timestamp[23:0], head.tracking[15:8]};
            4'd2: word_data = {head.order_ref[7:0], head.timestamp[47:24]};
            4'd3: word_data = head.order_ref[39:8];
            // side bit, side code, top of the reference
            4'd4: word_data = {7'b0, SIDE, SIDE_CODE, head.order_ref[61:40]};
            4'd5: word_data = head.quantity;
            4'd6: word_data = head.symbol_ascii[31:0];
            4'd7: word_data = head.symbol_ascii[63:32];
            4'd8: word_data = head.price;
            default: word_data = '0;
        endcase
    end

    assign o_word_valid = (count != '0);
    assign o_word.data  = word_data;
    assign o_word.first = (word_idx == 4'd0);
    assign o_word.last  = (word_idx == LAST_IDX);

    // quote credits must keep the sender from overrunning the queue
    a_no_overflow : assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        i_order_valid |-> (count != CNT_W'(QUOTE_DEPTH))
    );

    // merger only pops a presented word
    a_no_underflow : assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        i_word_pop |-> o_word_valid
    );

endmodule

//--- verilog/quote_stager.sv
`timescale 1ns/100ps

module quote_stager (
    input  logic                    i_clk,
    input  logic                    i_arst_n,

    // quote side, sender holds a credit for every valid
    input  logic                    i_quote_valid,
    input  order_entry_pkg::quote_t i_quote,

    // same-cycle handoff to both builders
    output logic                    o_order_valid,
    output order_entry_pkg::order_t o_buy_order,
    output order_entry_pkg::order_t o_sell_order
);

    // running even reference, 2n for the n-th accepted quote
    logic [61:0] ref_cnt;
    // ascii name of the incoming symbol
    logic [63:0] sym_ascii;

    // symbol lookup
    always_comb begin
        case (i_quote.symbol)
            order_entry_pkg::AAPL:  sym_ascii = order_entry_pkg::ASCII_AAPL;
            order_entry_pkg::AMZN:  sym_ascii = order_entry_pkg::ASCII_AMZN;
            order_entry_pkg::GOOGL: sym_ascii = order_entry_pkg::ASCII_GOOGL;
            order_entry_pkg::MSFT:  sym_ascii = order_entry_pkg::ASCII_MSFT;
            default:                sym_ascii = order_entry_pkg::ASCII_BLANK;
        endcase
    end

    // valid and reference counter
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_order_valid <= 1'b0;
            ref_cnt       <= '0;
        end else begin
            o_order_valid <= i_quote_valid;
            // two references used per quote
            if (i_quote_valid) begin
                ref_cnt <= ref_cnt + 62'd2;
            end
        end
    end

    // order payload, only loaded on an accepted quote
    always_ff @(posedge i_clk) begin
        if (i_quote_valid) begin
            // buy side
            o_buy_order.symbol_ascii  <= sym_ascii;
            o_buy_order.price         <= i_quote.buy_price;
            o_buy_order.quantity      <= i_quote.quantity;
            o_buy_order.locate        <= i_quote.locate;
            o_buy_order.tracking      <= i_quote.tracking;
            o_buy_order.timestamp     <= i_quote.timestamp;
            o_buy_order.order_ref     <= ref_cnt;

            // sell side, odd reference
            o_sell_order.symbol_ascii <= sym_ascii;
            o_sell_order.price        <= i_quote.sell_price;
            o_sell_order.quantity     <= i_quote.quantity;
            o_sell_order.locate       <= i_quote.locate;
            o_sell_order.tracking     <= i_quote.tracking;
            o_sell_order.timestamp    <= i_quote.timestamp;
            o_sell_order.order_ref    <= {ref_cnt[61:1], 1'b1};
        end
    end

    // builders latch whatever is here, so no x may leak into a queue
    a_order_known : assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        o_order_valid |-> !$isunknown({o_buy_order, o_sell_order})
    );

endmodule

//--- verilog/order_entry_pkg.sv
package order_entry_pkg;

    // order side, also the side bit of word 4
    typedef enum logic {
        BUY  = 1'b0,
        SELL = 1'b1
    } side_e;

    // traded symbols, encoding matches the quote feed
    typedef enum logic [1:0] {
        AAPL  = 2'd0,
        AMZN  = 2'd1,
        GOOGL = 2'd2,
        MSFT  = 2'd3
    } symbol_e;

    // one incoming quote
    typedef struct packed {
        symbol_e     symbol;
        logic [31:0] buy_price;
        logic [31:0] sell_price;
        logic [31:0] quantity;
        logic [15:0] locate;
        logic [15:0] tracking;
        logic [47:0] timestamp;
    } quote_t;

    // one side of a quote, ready for formatting
    typedef struct packed {
        logic [63:0] symbol_ascii;
        logic [31:0] price;
        logic [31:0] quantity;
        logic [15:0] locate;
        logic [15:0] tracking;
        logic [47:0] timestamp;
        logic [61:0] order_ref;
    } order_t;

    // one stream beat
    typedef struct packed {
        logic [31:0] data;
        logic        first;
        logic        last;
    } out_beat_t;

    // words per add-order message
    localparam int MSG_WORDS = 9;

    // add-order message type, ascii 'A'
    localparam logic [7:0] ADD_ORDER_TYPE = 8'h41;

    // space-padded symbol names
    localparam logic [63:0] ASCII_AAPL  = 64'h4141504c20202020;
    localparam logic [63:0] ASCII_AMZN  = 64'h414d5a4e20202020;
    localparam logic [63:0] ASCII_GOOGL = 64'h474f4f474c202020;
    localparam logic [63:0] ASCII_MSFT  = 64'h4d53465420202020;
    localparam logic [63:0] ASCII_BLANK = 64'h2020202020202020;

endpackage
